/* design/ll_params.svh */
`ifndef LL_PARAMS_SVH
`define LL_PARAMS_SVH

// lane count of the link
`define LL_LANES 2

// width of one lane or transport byte
`define LL_BYTE_W 8

// config register address width and map
`define LL_ADDR_W 2
`define LL_ADDR_CTRL 2'd0
`define LL_ADDR_TXCNT 2'd1
`define LL_ADDR_RXCNT 2'd2
`define LL_ADDR_ID 2'd3

// scrambler lfsr width and seed, seed must stay nonzero
`define LL_SCR_W 16
`define LL_SCR_SEED 16'hACE1

// identifier word returned at LL_ADDR_ID
`define LL_ID_VALUE 32'h4C4C_0002

`endif

/* design/ll_pkg.sv */
`default_nettype none

`include "ll_params.svh"

package ll_pkg;

	// one byte on a lane or on the transport side
	typedef logic [`LL_BYTE_W-1:0] ll_byte_t;

	// one config register word
	typedef logic [31:0] ll_reg_t;

	// control register, bit 0 is scramble_en
	// counter_clear is a pulse, cleared by hardware next cycle
	typedef struct packed {
		logic counter_clear;
		logic scramble_en;
	} ll_ctrl_t;

endpackage

`default_nettype wire

/* design/lane_if.sv */
`timescale 1ns/1ps
`default_nettype none

interface lane_if;
	import ll_pkg::*;

	// byte for each lane
	ll_byte_t lane0;
	ll_byte_t lane1;

	// word strobe, one cycle per word
	logic valid;

	// high when lane1 carries data too
	logic dual;

	// block that produces the word
	modport source (output lane0, lane1, valid, dual);

	// block that consumes the word
	modport sink (input lane0, lane1, valid, dual);

endinterface

`default_nettype wire

/* design/config_space.sv */
`timescale 1ns/1ps
`default_nettype none

`include "ll_params.svh"

module config_space (
	input  wire logic                 local_clk,
	input  wire logic                 rst,
	input  wire logic                 c_read,
	input  wire logic                 c_write,
	input  wire logic [`LL_ADDR_W-1:0] c_address,
	input  wire ll_pkg::ll_reg_t      c_data_in,
	output ll_pkg::ll_reg_t           c_data_out,
	input  wire logic                 tx_byte_accept,
	input  wire logic                 rx_byte_deliver,
	output logic                      scramble_en
);
	import ll_pkg::*;

	localparam int CTRL_W = $bits(ll_ctrl_t);

	ll_ctrl_t ctrl;
	ll_reg_t  tx_cnt;
	ll_reg_t  rx_cnt;
	logic     ctrl_wr;

	// write strobe for the control register
	assign ctrl_wr = c_write && (c_address == `LL_ADDR_CTRL);

	// control register
	always_ff @(posedge local_clk) begin
		if (rst) begin
			ctrl <= '0;
		end else if (ctrl_wr) begin
			// only the defined bits are kept
			ctrl <= c_data_in[CTRL_W-1:0];
		end else begin
			// clear pulse lasts one cycle
			ctrl.counter_clear <= 1'b0;
		end
	end

	assign scramble_en = ctrl.scramble_en;

	// tx byte counter, sticks at all ones
	always_ff @(posedge local_clk) begin
		if (rst || ctrl.counter_clear) begin
			tx_cnt <= '0;
		end else if (tx_byte_accept && (tx_cnt != '1)) begin
			tx_cnt <= tx_cnt + 1'b1;
		end
	end

	// rx byte counter, same rule
	always_ff @(posedge local_clk) begin
		if (rst || ctrl.counter_clear) begin
			rx_cnt <= '0;
		end else if (rx_byte_deliver && (rx_cnt != '1)) begin
			rx_cnt <= rx_cnt + 1'b1;
		end
	end

	// read data, held until the next read
	always_ff @(posedge local_clk) begin
		if (rst) begin
			c_data_out <= '0;
		end else if (c_read) begin
			case (c_address)
				`LL_ADDR_CTRL:  c_data_out <= {{(32-CTRL_W){1'b0}}, ctrl};
				`LL_ADDR_TXCNT: c_data_out <= tx_cnt;
				`LL_ADDR_RXCNT: c_data_out <= rx_cnt;
				default:        c_data_out <= `LL_ID_VALUE;
			endcase
		end
	end

	// register port is single access per cycle
	a_no_rd_wr: assert property (@(posedge local_clk) disable iff (rst)
		!(c_read && c_write));

endmodule

`default_nettype wire

/* design/tx_lane_striper.sv */
`timescale 1ns/1ps
`default_nettype none

module tx_lane_striper (
	input  wire logic             local_clk,
	input  wire logic             rst,
	input  wire ll_pkg::ll_byte_t transport_layer_data_in,
	input  wire logic             transport_layer_valid_in,
	input  wire logic             lane_disable,
	lane_if.source                lanes
);
	import ll_pkg::*;

	// first byte of a pair waits here
	ll_byte_t hold_byte;
	logic     hold_full;
	logic     lane_disable_q;
	logic     hold_live;

	// a lane mode change throws the half pair away
	assign hold_live = hold_full && (lane_disable == lane_disable_q);

	// strobes and hold state
	always_ff @(posedge local_clk) begin
		if (rst) begin
			hold_full      <= 1'b0;
			lane_disable_q <= 1'b1;
			lanes.valid    <= 1'b0;
			lanes.dual     <= 1'b0;
		end else begin
			lane_disable_q <= lane_disable;
			lanes.valid    <= 1'b0;
			hold_full      <= hold_live;
			if (transport_layer_valid_in) begin
				if (lane_disable) begin
					// lane 0 only
					lanes.valid <= 1'b1;
					lanes.dual  <= 1'b0;
					hold_full   <= 1'b0;
				end else if (hold_live) begin
					// second byte completes the pair
					lanes.valid <= 1'b1;
					lanes.dual  <= 1'b1;
					hold_full   <= 1'b0;
				end else begin
					hold_full <= 1'b1;
				end
			end
		end
	end

	// lane bytes
	always_ff @(posedge local_clk) begin
		if (transport_layer_valid_in) begin
			if (lane_disable) begin
				lanes.lane0 <= transport_layer_data_in;
				// idle lane sends zero
				lanes.lane1 <= '0;
			end else if (hold_live) begin
				lanes.lane0 <= hold_byte;
				lanes.lane1 <= transport_layer_data_in;
			end else begin
				hold_byte <= transport_layer_data_in;
			end
		end
	end

	// single words never carry leftover hold data on lane1
	a_single_clean: assert property (@(posedge local_clk) disable iff (rst)
		(lanes.valid && !lanes.dual) |-> (lanes.lane1 == '0) && !hold_full);

endmodule

`default_nettype wire

/* design/lane_scrambler.sv */
`timescale 1ns/1ps
`default_nettype none

`include "ll_params.svh"

module lane_scrambler (
	input  wire logic local_clk,
	input  wire logic rst,
	input  wire logic scramble_en,
	lane_if.sink      lanes_in,
	lane_if.source    lanes_out
);

	// one lfsr per lane
	logic [`LL_LANES-1:0][`LL_SCR_W-1:0] lfsr;
	logic [`LL_LANES-1:0][`LL_SCR_W-1:0] cur;
	logic scramble_en_q;
	logic reseed;
	logic adv0;
	logic adv1;

	// x^16+x^5+x^4+x^3+1, one byte worth of shifts
	function automatic logic [`LL_SCR_W-1:0] lfsr_step8(input logic [`LL_SCR_W-1:0] st);
		logic [`LL_SCR_W-1:0] s;
		logic fb;
		s = st;
		for (int i = 0; i < `LL_BYTE_W; i++) begin
			fb = s[15] ^ s[4] ^ s[3] ^ s[2];
			s  = {s[14:0], fb};
		end
		return s;
	endfunction

	// enable edge restarts both sequences
	assign reseed = scramble_en != scramble_en_q;

	// state used for this word
	assign cur[0] = reseed ? `LL_SCR_SEED : lfsr[0];
	assign cur[1] = reseed ? `LL_SCR_SEED : lfsr[1];

	// lane 1 holds still in single mode
	assign adv0 = lanes_in.valid && scramble_en;
	assign adv1 = adv0 && lanes_in.dual;

	always_ff @(posedge local_clk) begin
		if (rst) begin
			scramble_en_q   <= 1'b0;
			lfsr[0]         <= `LL_SCR_SEED;
			lfsr[1]         <= `LL_SCR_SEED;
			lanes_out.valid <= 1'b0;
			lanes_out.dual  <= 1'b0;
		end else begin
			scramble_en_q   <= scramble_en;
			lfsr[0]         <= adv0 ? lfsr_step8(cur[0]) : cur[0];
			lfsr[1]         <= adv1 ? lfsr_step8(cur[1]) : cur[1];
			lanes_out.valid <= lanes_in.valid;
			lanes_out.dual  <= lanes_in.dual;
		end
	end

	// xor with low byte of state, plain copy when off
	always_ff @(posedge local_clk) begin
		if (lanes_in.valid) begin
			lanes_out.lane0 <= adv0 ? lanes_in.lane0 ^ cur[0][7:0] : lanes_in.lane0;
			lanes_out.lane1 <= adv1 ? lanes_in.lane1 ^ cur[1][7:0] : lanes_in.lane1;
		end
	end

	// a zero lfsr would lock up
	a_lfsr_live: assert property (@(posedge local_clk) disable iff (rst)
		(lfsr[0] != '0) && (lfsr[1] != '0));

endmodule

`default_nettype wire

/* design/rx_lane_merger.sv */
`timescale 1ns/1ps
`default_nettype none

module rx_lane_merger (
	input  wire logic   local_clk,
	input  wire logic   rst,
	lane_if.sink        lanes,
	output ll_pkg::ll_byte_t transport_layer_data_out,
	output logic        transport_layer_valid_out
);
	import ll_pkg::*;

	// lane1 byte parked for one cycle
	ll_byte_t hold_byte;
	logic     hold_full;

	// strobes
	always_ff @(posedge local_clk) begin
		if (rst) begin
			transport_layer_valid_out <= 1'b0;
			hold_full                 <= 1'b0;
		end else begin
			// lane0 now or the parked lane1
			transport_layer_valid_out <= lanes.valid || hold_full;
			// dual word leaves lane1 behind
			hold_full <= lanes.valid && lanes.dual;
		end
	end

	// byte path
	always_ff @(posedge local_clk) begin
		if (lanes.valid) begin
			transport_layer_data_out <= lanes.lane0;
			hold_byte                <= lanes.lane1;
		end else if (hold_full) begin
			transport_layer_data_out <= hold_byte;
		end
	end

	// dual words must be spaced two cycles apart
	a_hold_free: assert property (@(posedge local_clk) disable iff (rst)
		lanes.valid |-> !hold_full);

endmodule

`default_nettype wire

/* design/logical_layer.sv */
`timescale 1ns/1ps
`default_nettype none

`include "ll_params.svh"

module logical_layer (
	input  wire logic                  local_clk,
	input  wire logic                  rst,
	input  wire logic                  c_read,
	input  wire logic                  c_write,
	input  wire logic [`LL_ADDR_W-1:0] c_address,
	input  wire ll_pkg::ll_reg_t       c_data_in,
	output ll_pkg::ll_reg_t            c_data_out,
	input  wire logic                  lane_disable,
	input  wire ll_pkg::ll_byte_t      transport_layer_data_in,
	input  wire logic                  transport_layer_valid_in,
	output ll_pkg::ll_byte_t           transport_layer_data_out,
	output logic                       transport_layer_valid_out,
	input  wire ll_pkg::ll_byte_t      lane_0_rx_i,
	input  wire ll_pkg::ll_byte_t      lane_1_rx_i,
	input  wire logic                  enable_deser,
	output ll_pkg::ll_byte_t           lane_0_tx_o,
	output ll_pkg::ll_byte_t           lane_1_tx_o,
	output logic                       lane_tx_valid,
	output logic                       enable_scr
);

	logic scramble_en;

	// tx: striper out, scrambler out
	lane_if tx_raw ();
	lane_if tx_scr ();

	// rx: pins in, descrambler out
	lane_if rx_raw ();
	lane_if rx_scr ();

	// register file, counts bytes at both transport edges
	config_space u_config (
		.local_clk       (local_clk),
		.rst             (rst),
		.c_read          (c_read),
		.c_write         (c_write),
		.c_address       (c_address),
		.c_data_in       (c_data_in),
		.c_data_out      (c_data_out),
		.tx_byte_accept  (transport_layer_valid_in),
		.rx_byte_deliver (transport_layer_valid_out),
		.scramble_en     (scramble_en)
	);

	assign enable_scr = scramble_en;

	// transmit path
	tx_lane_striper u_striper (
		.local_clk                (local_clk),
		.rst                      (rst),
		.transport_layer_data_in  (transport_layer_data_in),
		.transport_layer_valid_in (transport_layer_valid_in),
		.lane_disable             (lane_disable),
		.lanes                    (tx_raw)
	);

	lane_scrambler u_tx_scr (
		.local_clk   (local_clk),
		.rst         (rst),
		.scramble_en (scramble_en),
		.lanes_in    (tx_raw),
		.lanes_out   (tx_scr)
	);

	assign lane_0_tx_o   = tx_scr.lane0;
	assign lane_1_tx_o   = tx_scr.lane1;
	assign lane_tx_valid = tx_scr.valid;

	// receive word straight from the pins
	assign rx_raw.lane0 = lane_0_rx_i;
	assign rx_raw.lane1 = lane_1_rx_i;
	assign rx_raw.valid = enable_deser;
	assign rx_raw.dual  = ~lane_disable;

	// same additive sequence undoes the tx scrambling
	lane_scrambler u_rx_scr (
		.local_clk   (local_clk),
		.rst         (rst),
		.scramble_en (scramble_en),
		.lanes_in    (rx_raw),
		.lanes_out   (rx_scr)
	);

	rx_lane_merger u_merger (
		.local_clk                 (local_clk),
		.rst                       (rst),
		.lanes                     (rx_scr),
		.transport_layer_data_out  (transport_layer_data_out),
		.transport_layer_valid_out (transport_layer_valid_out)
	);

endmodule

`default_nettype wire

/* verification/tb_logical_layer.sv */
`timescale 1ns/1ps
`default_nettype none

`include "ll_params.svh"

module tb_logical_layer;
	import ll_pkg::*;

	logic                  local_clk;
	logic                  rst;
	logic                  c_read;
	logic                  c_write;
	logic [`LL_ADDR_W-1:0] c_address;
	ll_reg_t               c_data_in;
	ll_reg_t               c_data_out;
	logic                  lane_disable;
	ll_byte_t              transport_layer_data_in;
	logic                  transport_layer_valid_in;
	ll_byte_t              transport_layer_data_out;
	logic                  transport_layer_valid_out;
	ll_byte_t              lane_0_tx_o;
	ll_byte_t              lane_1_tx_o;
	logic                  lane_tx_valid;
	logic                  enable_scr;

	// run bookkeeping
	integer   seed = 66;
	int       cyc = 0;
	int       checks = 0;
	int       errors = 0;
	int       timeouts = 0;
	string    test_name = "init";
	// bytes sent and not yet back on the transport output
	ll_byte_t sent_q[$];
	// expected lane words, keyed by the cycle they show up
	ll_byte_t due_l0[int];
	ll_byte_t due_l1[int];
	logic     due_dual[int];

	// tx lanes looped straight back into rx
	logical_layer dut (
		.local_clk                 (local_clk),
		.rst                       (rst),
		.c_read                    (c_read),
		.c_write                   (c_write),
		.c_address                 (c_address),
		.c_data_in                 (c_data_in),
		.c_data_out                (c_data_out),
		.lane_disable              (lane_disable),
		.transport_layer_data_in   (transport_layer_data_in),
		.transport_layer_valid_in  (transport_layer_valid_in),
		.transport_layer_data_out  (transport_layer_data_out),
		.transport_layer_valid_out (transport_layer_valid_out),
		.lane_0_rx_i               (lane_0_tx_o),
		.lane_1_rx_i               (lane_1_tx_o),
		.enable_deser              (lane_tx_valid),
		.lane_0_tx_o               (lane_0_tx_o),
		.lane_1_tx_o               (lane_1_tx_o),
		.lane_tx_valid             (lane_tx_valid),
		.enable_scr                (enable_scr)
	);

	// 20 ns clock
	initial local_clk = 1'b0;
	always #10 local_clk = ~local_clk;

	// cycle count, read on the falling edge
	always @(posedge local_clk) begin
		cyc <= cyc + 1;
	end

	task automatic check_value(input string what, input logic [31:0] expected,
			input logic [31:0] actual);
		checks++;
		if (actual !== expected) begin
			errors++;
			$display("CHECK FAILED %s %s expected %h actual %h", test_name, what, expected,
				actual);
		end
	endtask

	// write takes one cycle, then an idle cycle so the register settles
	task automatic reg_write(input logic [`LL_ADDR_W-1:0] addr, input ll_reg_t data);
		c_write   = 1'b1;
		c_address = addr;
		c_data_in = data;
		@(negedge local_clk);
		c_write = 1'b0;
		@(negedge local_clk);
	endtask

	// read data is there one cycle after c_read
	task automatic reg_read(input logic [`LL_ADDR_W-1:0] addr, input ll_reg_t expected);
		c_read    = 1'b1;
		c_address = addr;
		@(negedge local_clk);
		c_read = 1'b0;
		check_value("read", expected, c_data_out);
	endtask

	// sends whole words, optionally checks the lanes, then waits for the loopback
	task automatic send_words(input logic single, input int words, input logic check_lanes,
			input ll_byte_t key);
		ll_byte_t b0;
		ll_byte_t b1;
		int       w;
		int       wait_cnt;
		b1 = '0;
		lane_disable = single;
		@(negedge local_clk);
		for (w = 0; w < words; w++) begin
			b0 = ll_byte_t'($random(seed));
			transport_layer_valid_in = 1'b1;
			transport_layer_data_in  = b0;
			sent_q.push_back(b0);
			if (!single) begin
				// second byte of the pair goes to lane 1
				@(negedge local_clk);
				b1 = ll_byte_t'($random(seed));
				transport_layer_data_in = b1;
				sent_q.push_back(b1);
			end
			if (check_lanes) begin
				// word is on the lanes two cycles after its last byte
				due_l0[cyc + 2]   = b0 ^ key;
				due_l1[cyc + 2]   = b1 ^ key;
				due_dual[cyc + 2] = !single;
			end
			@(negedge local_clk);
		end
		transport_layer_valid_in = 1'b0;
		wait_cnt = 0;
		while (sent_q.size() != 0 && wait_cnt < 200) begin
			@(negedge local_clk);
			wait_cnt++;
		end
		if (sent_q.size() != 0) begin
			timeouts++;
			$display("test %s timed out, %0d sent bytes never came back", test_name,
				sent_q.size());
			sent_q.delete();
		end
		// let the counters catch up
		for (w = 0; w < 3; w++) begin
			@(negedge local_clk);
		end
	endtask

	task automatic run_record(input string op, input logic [31:0] a, input logic [31:0] b,
			input logic [31:0] c);
		if (op == "wr") begin
			reg_write(a[`LL_ADDR_W-1:0], b);
		end else if (op == "rd") begin
			reg_read(a[`LL_ADDR_W-1:0], b);
		end else if (op == "scr") begin
			check_value("enable_scr", b, {31'b0, enable_scr});
		end else if (op == "tx") begin
			send_words(a[0], b, c[0], 8'h00);
		end else if (op == "first") begin
			send_words(a[0], 1, 1'b1, b[7:0]);
		end else begin
			errors++;
			$display("test %s has an unknown operation %s", test_name, op);
		end
	endtask

	// received stream must match the sent stream in order
	always @(negedge local_clk) begin
		if (!rst && transport_layer_valid_out) begin
			if (sent_q.size() == 0) begin
				errors++;
				$display("test %s got byte %h on the transport output with none outstanding",
					test_name, transport_layer_data_out);
			end else begin
				check_value("rx_byte", {24'b0, sent_q.pop_front()},
					{24'b0, transport_layer_data_out});
			end
		end
	end

	// lane words at their due cycle
	always @(negedge local_clk) begin
		if (due_l0.exists(cyc)) begin
			check_value("lane_tx_valid", 32'd1, {31'b0, lane_tx_valid});
			check_value("lane0", {24'b0, due_l0[cyc]}, {24'b0, lane_0_tx_o});
			if (due_dual[cyc]) begin
				check_value("lane1", {24'b0, due_l1[cyc]}, {24'b0, lane_1_tx_o});
			end
			due_l0.delete(cyc);
			due_l1.delete(cyc);
			due_dual.delete(cyc);
		end
	end

	initial begin
		int          fd;
		int          n;
		int          i;
		string       line;
		string       op;
		logic [31:0] a;
		logic [31:0] b;
		logic [31:0] c;
		rst                      = 1'b1;
		c_read                   = 1'b0;
		c_write                  = 1'b0;
		c_address                = '0;
		c_data_in                = '0;
		lane_disable             = 1'b1;
		transport_layer_data_in  = '0;
		transport_layer_valid_in = 1'b0;
		fd = $fopen("verification/ll_tests.txt", "r");
		if (fd == 0) begin
			errors++;
			$display("could not open verification/ll_tests.txt");
		end
		for (i = 0; i < 8; i++) begin
			@(negedge local_clk);
		end
		rst = 1'b0;
		// strobes and scramble enable come out of reset low
		test_name = "reset";
		check_value("lane_tx_valid", 32'd0, {31'b0, lane_tx_valid});
		check_value("valid_out", 32'd0, {31'b0, transport_layer_valid_out});
		check_value("enable_scr", 32'd0, {31'b0, enable_scr});
		while (fd != 0 && !$feof(fd)) begin
			line = "";
			n = $fgets(line, fd);
			// skip blank and comment lines
			if (n > 1 && line.getc(0) != "#") begin
				n = $sscanf(line, "%s %s %h %h %h", test_name, op, a, b, c);
				if (n != 5) begin
					errors++;
					$display("malformed test record: %s", line);
				end else begin
					run_record(op, a, b, c);
				end
			end
		end
		if (fd != 0) begin
			$fclose(fd);
		end
		$display("checks %0d, errors %0d, timeouts %0d", checks, errors, timeouts);
		if (errors == 0 && timeouts == 0) begin
			$display("TEST PASS");
		end else begin
			$display("TEST FAIL");
		end
		$finish;
	end

endmodule

`default_nettype wire

/* verification/ll_tests.txt */
# name op a b c, numbers in hex
# wr a=addr b=data, rd a=addr b=expected, scr b=expected enable_scr
# tx a=lane_disable b=words c=check lanes, first a=lane_disable b=key of first word
id_reg        rd    3 4c4c0002 0
ctrl_reset    rd    0 0        0
scr_reset     scr   0 0        0
single_first  first 1 0        0
single_plain  tx    1 20       1
dual_plain    tx    0 10       1
cnt_tx_plain  rd    1 41       0
cnt_rx_plain  rd    2 41       0
ctrl_mask     wr    0 fffffffd 0
ctrl_mask_rd  rd    0 1        0
scr_on        scr   0 1        0
scr_first_s   first 1 e1       0
scr_single    tx    1 20       0
scr_dual      tx    0 20       0
scr_off       wr    0 0        0
scr_on_again  wr    0 1        0
scr_first_d   first 0 e1       0
scr_dual_more tx    0 10       0
cnt_tx_all    rd    1 c4       0
cnt_rx_all    rd    2 c4       0
cnt_clear     wr    0 3        0
cnt_tx_zero   rd    1 0        0
cnt_rx_zero   rd    2 0        0
ctrl_cleared  rd    0 1        0

/* tb.f */
+incdir+design
design/ll_pkg.sv
design/lane_if.sv
design/config_space.sv
design/tx_lane_striper.sv
design/lane_scrambler.sv
design/rx_lane_merger.sv
design/logical_layer.sv
verification/tb_logical_layer.sv

/* Makefile */
VERILATOR = verilator
VFLAGS    = --binary --timing --assert -Wno-fatal
TOP       = tb_logical_layer
FILELIST  = tb.f
OBJ_DIR   = obj_dir

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --Mdir $(OBJ_DIR) --top-module $(TOP) -f $(FILELIST)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; echo "$$out"; echo "$$out" | grep -qx "TEST PASS"

clean:
	rm -rf $(OBJ_DIR)
